/* project.f */
src/dmem_pkg.sv
src/dmem_reqbuf.sv
src/dmem_lane_unit.sv
src/dmem_pma_chk.sv
src/dmem_ctrl.sv
src/dmem_top.sv
testbench/dmem_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := dmem_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status of the simulation binary is the test result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/dmem_stim.txt */
# we size addr wdata exp_rdata exp_err exp_misaligned inject_bus_err bus_expected
# all columns hex, size 0 byte, 1 half, 2 word
1 2 00000100 12345678 00000000 0 0 0 1
0 2 00000100 00000000 12345678 0 0 0 1
1 0 00000201 000000ab 00000000 0 0 0 1
1 1 00000202 0000beef 00000000 0 0 0 1
0 2 00000200 00000000 beefab00 0 0 0 1
0 0 00000203 00000000 000000be 0 0 0 1
0 1 00000200 00000000 0000ab00 0 0 0 1
0 0 00000101 00000000 00000056 0 0 0 1
0 1 00000103 00000000 00000000 0 1 0 0
1 2 00000102 ffffffff 00000000 0 1 0 0
0 2 00005002 00000000 00000000 0 1 0 0
1 2 00001000 a5a5a5a5 00000000 1 0 0 0
0 2 00004000 00000000 00000000 1 0 0 0
0 2 00001004 00000000 dead1004 0 0 0 1
0 1 0000100a 00000000 0000dead 0 0 0 1
0 2 00000300 00000000 00000000 1 0 1 1
0 2 00000100 00000000 12345678 0 0 0 1
1 2 00000400 cafef00d 00000000 0 0 0 1
0 2 00000400 00000000 cafef00d 0 0 0 1
1 0 000007ff 00000011 00000000 0 0 0 1
0 2 000007fc 00000000 11ad07fc 0 0 0 1
0 0 00000fff 00000000 000000de 0 0 0 1
0 0 00001ffd 00000000 0000001f 0 0 0 1
0 2 00002000 00000000 00000000 1 0 0 0
1 2 00000500 00000055 00000000 1 0 1 1
0 1 00000202 00000000 0000beef 0 0 0 1

/* testbench/dmem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_tb;

  // Cycle limits for the wait loops
  localparam int RDY_TIMEOUT     = 200;
  localparam int RELEASE_TIMEOUT = 50;
  localparam int DONE_TIMEOUT    = 2000;
  localparam int MEM_WORDS       = 2048;

  // One line of the stimulus file
  typedef struct packed {
    dmem_pkg::cpu_req_t req;
    dmem_pkg::cpu_rsp_t rsp;
    logic               inj;
    logic               bus;
  } stim_t;

  // Expected response plus bus transfers seen by then
  typedef struct packed {
    dmem_pkg::cpu_rsp_t rsp;
    logic [31:0]        bus_total;
  } exp_t;

  // What the bus slave expects for the next transfer
  typedef struct packed {
    logic            inj;
    logic            we;
    dmem_pkg::addr_t adr;
  } bus_item_t;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 cpu_valid_i;
  dmem_pkg::cpu_req_t   cpu_req_i;
  logic                 cpu_rdy_o;
  logic                 cpu_ack_o;
  dmem_pkg::cpu_rsp_t   cpu_rsp_o;
  logic                 bus_req_o;
  dmem_pkg::bus_req_t   bus_req_data_o;
  logic                 bus_ack_i;
  dmem_pkg::word_t      bus_rdata_i;
  logic                 bus_err_i;

  stim_t                stim_q[$];
  exp_t                 exp_q[$];
  bus_item_t            bus_q[$];
  dmem_pkg::word_t      mem [MEM_WORDS];
  logic [31:0]          bus_seen_cnt;
  int                   resp_cnt;
  logic                 rdy_low_seen;
  integer               seed;

  dmem_top i_dmem_top (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .cpu_valid_i    ( cpu_valid_i    ),
    .cpu_req_i      ( cpu_req_i      ),
    .cpu_rdy_o      ( cpu_rdy_o      ),
    .cpu_ack_o      ( cpu_ack_o      ),
    .cpu_rsp_o      ( cpu_rsp_o      ),
    .bus_req_o      ( bus_req_o      ),
    .bus_req_data_o ( bus_req_data_o ),
    .bus_ack_i      ( bus_ack_i      ),
    .bus_rdata_i    ( bus_rdata_i    ),
    .bus_err_i      ( bus_err_i      )
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic fail_run(input string reason);
    $display("%s", reason);
    stop_run();
  endtask

  task automatic value_error(input string field, input dmem_pkg::word_t got,
                             input dmem_pkg::word_t expected);
    $display("[ERROR] %0t: %s mismatch, got %h expected %h", $time, field, got, expected);
    stop_run();
  endtask

  // Background contents differ for every word address
  function automatic dmem_pkg::word_t fill_word(input dmem_pkg::addr_t adr);
    return 32'hDEAD_0000 ^ adr;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////////////////////////////////////////

  task automatic read_stimulus();
    int              fd;
    int              code;
    int              n;
    string           line;
    stim_t           s;
    logic            we_v;
    logic [1:0]      size_v;
    dmem_pkg::word_t adr_v;
    dmem_pkg::word_t wdata_v;
    dmem_pkg::word_t rdata_v;
    logic            err_v;
    logic            mis_v;
    logic            inj_v;
    logic            bus_v;
    fd = $fopen("testbench/dmem_stim.txt", "r");
    if (fd == 0)
      fail_run("cannot open testbench/dmem_stim.txt");
    while (!$feof(fd))
    begin
      line = "";
      code = $fgets(line, fd);
      // Skip header and blank lines
      if (code > 0 && line.getc(0) != "#")
      begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", we_v, size_v, adr_v, wdata_v,
                    rdata_v, err_v, mis_v, inj_v, bus_v);
        if (n == 9)
        begin
          s.req.we         = we_v;
          s.req.size       = size_v;
          s.req.adr        = adr_v;
          s.req.wdata      = wdata_v;
          s.rsp.rdata      = rdata_v;
          s.rsp.err        = err_v;
          s.rsp.misaligned = mis_v;
          s.inj            = inj_v;
          s.bus            = bus_v;
          stim_q.push_back(s);
        end
        else if (n > 0)
          fail_run("malformed line in stimulus file");
      end
    end
    $fclose(fd);
    if (stim_q.size() == 0)
      fail_run("stimulus file holds no accesses");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // CPU side driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_requests();
    int          idx;
    int          stall;
    logic [31:0] bus_total;
    exp_t        e;
    bus_item_t   b;
    idx       = 0;
    stall     = 0;
    bus_total = '0;
    while (idx < stim_q.size())
    begin
      @(negedge clk_i);
      // Ready is stable until the next rising edge
      if (cpu_rdy_o)
      begin
        cpu_valid_i = 1'b1;
        cpu_req_i   = stim_q[idx].req;
        bus_total   = bus_total + {31'd0, stim_q[idx].bus};
        e.rsp       = stim_q[idx].rsp;
        e.bus_total = bus_total;
        exp_q.push_back(e);
        if (stim_q[idx].bus)
        begin
          b.inj = stim_q[idx].inj;
          b.we  = stim_q[idx].req.we;
          b.adr = stim_q[idx].req.adr;
          bus_q.push_back(b);
        end
        idx   = idx + 1;
        stall = 0;
      end
      else
      begin
        cpu_valid_i = 1'b0;
        stall       = stall + 1;
        if (stall > RDY_TIMEOUT)
          fail_run("timeout: cpu_rdy_o stayed low");
      end
    end
    @(negedge clk_i);
    cpu_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus slave model
  ////////////////////////////////////////////////////////////////////////////

  task automatic serve_bus_transfer();
    bus_item_t  item;
    int         delay;
    int         wait_cycles;
    logic [10:0] word_idx;
    bus_seen_cnt = bus_seen_cnt + 32'd1;
    if (bus_q.size() == 0)
      fail_run("bus request seen for an access that must not reach the bus");
    else
    begin
      item = bus_q.pop_front();
      assert (bus_req_data_o.adr == {item.adr[31:2], 2'b00})
        else value_error("bus address", bus_req_data_o.adr, {item.adr[31:2], 2'b00});
      assert (bus_req_data_o.we == item.we)
        else value_error("bus write enable", dmem_pkg::word_t'(bus_req_data_o.we),
                         dmem_pkg::word_t'(item.we));
      // Random ack latency of 0 to 3 cycles
      delay = {$random(seed)} % 4;
      for (int d = 0; d < delay; d++)
      begin
        @(negedge clk_i);
        assert (bus_req_o)
          else fail_run("bus request dropped before the ack");
      end
      word_idx    = bus_req_data_o.adr[12:2];
      bus_err_i   = item.inj;
      bus_rdata_i = item.inj ? '0 : mem[word_idx];
      // Injected errors leave memory untouched
      if (bus_req_data_o.we && !item.inj)
      begin
        for (int k = 0; k < 4; k++)
        begin
          if (bus_req_data_o.be[k])
            mem[word_idx][8*k +: 8] = bus_req_data_o.wdata[8*k +: 8];
        end
      end
      bus_ack_i   = 1'b1;
      wait_cycles = 0;
      while (bus_req_o)
      begin
        @(negedge clk_i);
        wait_cycles = wait_cycles + 1;
        if (wait_cycles > RELEASE_TIMEOUT)
          fail_run("timeout: bus request not released after the ack");
      end
      // Four-phase release
      bus_ack_i   = 1'b0;
      bus_err_i   = 1'b0;
      bus_rdata_i = '0;
    end
  endtask

  initial
  begin
    seed         = 29690;
    bus_ack_i    = 1'b0;
    bus_err_i    = 1'b0;
    bus_rdata_i  = '0;
    bus_seen_cnt = '0;
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = fill_word(dmem_pkg::addr_t'(i) << 2);
    forever
    begin
      @(negedge clk_i);
      if (rst_n_i && bus_req_o)
        serve_bus_transfer();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response checker
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_response();
    exp_t e;
    if (exp_q.size() == 0)
      fail_run("response pulse with no request outstanding");
    else
    begin
      e = exp_q.pop_front();
      assert (cpu_rsp_o.rdata == e.rsp.rdata)
        else value_error("read data", cpu_rsp_o.rdata, e.rsp.rdata);
      assert (cpu_rsp_o.err == e.rsp.err)
        else value_error("err flag", dmem_pkg::word_t'(cpu_rsp_o.err),
                         dmem_pkg::word_t'(e.rsp.err));
      assert (cpu_rsp_o.misaligned == e.rsp.misaligned)
        else value_error("misaligned flag", dmem_pkg::word_t'(cpu_rsp_o.misaligned),
                         dmem_pkg::word_t'(e.rsp.misaligned));
      // Faulted accesses add no bus transfer
      assert (bus_seen_cnt == e.bus_total)
        else value_error("bus transfer count", bus_seen_cnt, e.bus_total);
      resp_cnt = resp_cnt + 1;
    end
  endtask

  always @(negedge clk_i)
  begin
    if (rst_n_i && cpu_ack_o)
      check_response();
    if (rst_n_i && !cpu_rdy_o)
      rdy_low_seen = 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int wait_cycles;
    rst_n_i      = 1'b0;
    cpu_valid_i  = 1'b0;
    cpu_req_i    = '0;
    resp_cnt     = 0;
    rdy_low_seen = 1'b0;
    read_stimulus();
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Idle outputs right out of reset
    assert (!cpu_ack_o)
      else value_error("cpu_ack_o after reset", dmem_pkg::word_t'(cpu_ack_o), '0);
    assert (!bus_req_o)
      else value_error("bus_req_o after reset", dmem_pkg::word_t'(bus_req_o), '0);
    assert (cpu_rdy_o)
      else value_error("cpu_rdy_o after reset", dmem_pkg::word_t'(cpu_rdy_o), 32'd1);

    drive_requests();

    wait_cycles = 0;
    while (resp_cnt < stim_q.size())
    begin
      @(negedge clk_i);
      wait_cycles = wait_cycles + 1;
      if (wait_cycles > DONE_TIMEOUT)
        fail_run("timeout: not all responses arrived");
    end

    // Back-to-back traffic must have filled the buffer
    if (rdy_low_seen)
    begin
      $display("all tests passed");
      $finish;
    end
    else
      fail_run("cpu_rdy_o never dropped during back-to-back requests");
  end

endmodule

`default_nettype wire

/* src/dmem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_top (
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,

  // CPU side
  input  wire logic          cpu_valid_i,
  input  dmem_pkg::cpu_req_t cpu_req_i,
  output logic               cpu_rdy_o,
  output logic               cpu_ack_o,
  output dmem_pkg::cpu_rsp_t cpu_rsp_o,

  // Bus side
  output logic               bus_req_o,
  output dmem_pkg::bus_req_t bus_req_data_o,
  input  wire logic          bus_ack_i,
  input  dmem_pkg::word_t    bus_rdata_i,
  input  wire logic          bus_err_i
);

  // Buffer status and head
  logic               push;
  logic               pop;
  logic               full;
  logic               head_valid;
  dmem_pkg::cpu_req_t head;

  // Check results
  logic               misaligned;
  logic               access_fault;

  // Lane data
  dmem_pkg::be_t      be;
  dmem_pkg::word_t    wdata;
  dmem_pkg::word_t    rdata;

  // Accept only while there is room
  assign cpu_rdy_o = ~full;
  assign push      = cpu_valid_i & cpu_rdy_o;

  ////////////////////////////////////////////////////////////////////////////
  // Request buffer
  ////////////////////////////////////////////////////////////////////////////

  dmem_reqbuf i_dmem_reqbuf (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .push_i       ( push       ),
    .push_data_i  ( cpu_req_i  ),
    .pop_i        ( pop        ),
    .head_o       ( head       ),
    .head_valid_o ( head_valid ),
    .full_o       ( full       )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Head checks and lane handling
  ////////////////////////////////////////////////////////////////////////////

  dmem_lane_unit i_dmem_lane_unit (
    .req_i        ( head        ),
    .bus_rdata_i  ( bus_rdata_i ),
    .misaligned_o ( misaligned  ),
    .be_o         ( be          ),
    .wdata_o      ( wdata       ),
    .rdata_o      ( rdata       )
  );

  dmem_pma_chk i_dmem_pma_chk (
    .adr_i          ( head.adr     ),
    .we_i           ( head.we      ),
    .access_fault_o ( access_fault )
  );

  // Sequencer for checks, bus and response
  dmem_ctrl i_dmem_ctrl (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .head_valid_i   ( head_valid     ),
    .head_i         ( head           ),
    .misaligned_i   ( misaligned     ),
    .access_fault_i ( access_fault   ),
    .be_i           ( be             ),
    .wdata_i        ( wdata          ),
    .rdata_i        ( rdata          ),
    .bus_ack_i      ( bus_ack_i      ),
    .bus_err_i      ( bus_err_i      ),
    .bus_req_o      ( bus_req_o      ),
    .bus_req_data_o ( bus_req_data_o ),
    .pop_o          ( pop            ),
    .cpu_ack_o      ( cpu_ack_o      ),
    .cpu_rsp_o      ( cpu_rsp_o      )
  );

endmodule

`default_nettype wire

/* src/dmem_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_ctrl (
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,

  // Head of the request buffer
  input  wire logic          head_valid_i,
  input  dmem_pkg::cpu_req_t head_i,

  // Check results
  input  wire logic          misaligned_i,
  input  wire logic          access_fault_i,

  // Lane unit
  input  dmem_pkg::be_t      be_i,
  input  dmem_pkg::word_t    wdata_i,
  input  dmem_pkg::word_t    rdata_i,

  // Bus side, four phase
  input  wire logic          bus_ack_i,
  input  wire logic          bus_err_i,
  output logic               bus_req_o,
  output dmem_pkg::bus_req_t bus_req_data_o,

  // CPU side
  output logic               pop_o,
  output logic               cpu_ack_o,
  output dmem_pkg::cpu_rsp_t cpu_rsp_o
);

  typedef enum logic [1:0] {
    IDLE,
    BUS_REQ,
    BUS_RELEASE,
    RESPOND
  } state_e;

  state_e state_q;
  state_e state_d;

  // Either check stops the access before the bus
  logic check_fail;

  dmem_pkg::bus_req_t bus_req_q;
  dmem_pkg::cpu_rsp_t rsp_q;

  assign check_fail = misaligned_i | access_fault_i;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (head_valid_i)
          state_d = check_fail ? RESPOND : BUS_REQ;
      // Hold request until slave acks
      BUS_REQ:
        if (bus_ack_i)
          state_d = BUS_RELEASE;
      // Wait for ack to drop before finishing
      BUS_RELEASE:
        if (!bus_ack_i)
          state_d = RESPOND;
      RESPOND:
        state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus request and response capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE && head_valid_i)
    begin
      if (check_fail)
      begin
        // Misaligned wins over access fault
        rsp_q <= '{rdata: '0,
                   err: ~misaligned_i & access_fault_i,
                   misaligned: misaligned_i};
      end
      else
      begin
        // Word address with lanes picked by enables
        bus_req_q <= '{we: head_i.we,
                       adr: {head_i.adr[dmem_pkg::XLEN-1:2], 2'b00},
                       be: be_i,
                       wdata: wdata_i};
      end
    end

    // Sample on the first edge with ack high
    if (state_q == BUS_REQ && bus_ack_i)
    begin
      rsp_q <= '{rdata: head_i.we ? '0 : rdata_i,
                 err: bus_err_i,
                 misaligned: 1'b0};
    end
  end

  // Outputs decoded from state
  assign bus_req_o      = (state_q == BUS_REQ);
  assign bus_req_data_o = bus_req_q;
  assign cpu_ack_o      = (state_q == RESPOND);
  // Head retires with its response
  assign pop_o          = (state_q == RESPOND);
  assign cpu_rsp_o      = rsp_q;

endmodule

`default_nettype wire

/* src/dmem_pma_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_pma_chk (
  input  dmem_pkg::addr_t adr_i,
  input  wire logic       we_i,
  output logic            access_fault_o
);

  // Region hits
  logic ram_hit;
  logic rom_hit;

  // Access rights of the region that was hit
  logic read_ok;
  logic write_ok;

  ////////////////////////////////////////////////////////////////////////////
  // Region lookup
  ////////////////////////////////////////////////////////////////////////////

  // Bounds are inclusive on both ends
  assign ram_hit = (adr_i >= dmem_pkg::RAM_BASE) && (adr_i <= dmem_pkg::RAM_LIMIT);
  assign rom_hit = (adr_i >= dmem_pkg::ROM_BASE) && (adr_i <= dmem_pkg::ROM_LIMIT);

  // Any mapped region can be read
  assign read_ok  = ram_hit | rom_hit;
  // Only RAM takes stores
  assign write_ok = ram_hit;

  ////////////////////////////////////////////////////////////////////////////
  // Fault decision
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    if (we_i)
      access_fault_o = ~write_ok;
    else
      access_fault_o = ~read_ok;
  end

endmodule

`default_nettype wire

/* src/dmem_lane_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_lane_unit (
  input  dmem_pkg::cpu_req_t req_i,
  input  dmem_pkg::word_t    bus_rdata_i,
  output logic               misaligned_o,
  output dmem_pkg::be_t      be_o,
  output dmem_pkg::word_t    wdata_o,
  output dmem_pkg::word_t    rdata_o
);

  // Byte offset inside the word
  logic [1:0]      byte_ofs;
  // Read word with the addressed byte moved to lane 0
  dmem_pkg::word_t rdata_shifted;

  assign byte_ofs      = req_i.adr[1:0];
  assign rdata_shifted = bus_rdata_i >> {byte_ofs, 3'b000};

  ////////////////////////////////////////////////////////////////////////////
  // Natural alignment check
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (req_i.size)
      dmem_pkg::SIZE_BYTE: misaligned_o = 1'b0;
      dmem_pkg::SIZE_HALF: misaligned_o = byte_ofs[0];
      dmem_pkg::SIZE_WORD: misaligned_o = (byte_ofs != 2'b00);
      // Unused size code never goes to the bus
      default:             misaligned_o = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write lanes
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (req_i.size)
      dmem_pkg::SIZE_BYTE:
      begin
        be_o    = dmem_pkg::be_t'(4'b0001) << byte_ofs;
        // Same byte in all four lanes
        wdata_o = {4{req_i.wdata[7:0]}};
      end
      dmem_pkg::SIZE_HALF:
      begin
        be_o    = dmem_pkg::be_t'(4'b0011) << {byte_ofs[1], 1'b0};
        // Low or high half selected by enables
        wdata_o = {2{req_i.wdata[15:0]}};
      end
      default:
      begin
        be_o    = 4'b1111;
        wdata_o = req_i.wdata;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read lane extraction, zero extended
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (req_i.size)
      dmem_pkg::SIZE_BYTE: rdata_o = {24'h00_0000, rdata_shifted[7:0]};
      dmem_pkg::SIZE_HALF: rdata_o = {16'h0000, rdata_shifted[15:0]};
      default:             rdata_o = bus_rdata_i;
    endcase
  end

endmodule

`default_nettype wire

/* src/dmem_reqbuf.sv */
`timescale 1ns/100ps
`default_nettype none

module dmem_reqbuf (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               push_i,
  input  dmem_pkg::cpu_req_t      push_data_i,
  input  wire logic               pop_i,
  output dmem_pkg::cpu_req_t      head_o,
  output logic                    head_valid_o,
  output logic                    full_o
);

  // Entry storage
  dmem_pkg::cpu_req_t entry_q [dmem_pkg::REQBUF_DEPTH];

  dmem_pkg::reqbuf_ptr_t wr_ptr_q;
  dmem_pkg::reqbuf_ptr_t rd_ptr_q;
  dmem_pkg::reqbuf_cnt_t cnt_q;

  logic do_push;
  logic do_pop;

  // Circular increment
  function automatic dmem_pkg::reqbuf_ptr_t next_ptr(input dmem_pkg::reqbuf_ptr_t ptr);
    if (ptr == dmem_pkg::REQBUF_LAST_PTR)
      return '0;
    else
      return ptr + dmem_pkg::reqbuf_ptr_t'(1);
  endfunction

  // Guard against overflow and underflow
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & head_valid_o;

  // Status flags
  assign head_valid_o = (cnt_q != '0);
  assign full_o       = (cnt_q == dmem_pkg::REQBUF_FULL_CNT);
  assign head_o       = entry_q[rd_ptr_q];

  always_ff @(posedge clk_i)
  begin
    if (do_push)
      entry_q[wr_ptr_q] <= push_data_i;
  end

  // Pointers and occupancy
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      // Simultaneous push and pop leaves count unchanged
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + dmem_pkg::reqbuf_cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - dmem_pkg::reqbuf_cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/dmem_pkg.sv */
`default_nettype none

package dmem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and basic types
  ////////////////////////////////////////////////////////////////////////////

  // Data and address width
  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [XLEN-1:0]   addr_t;
  typedef logic [1:0]        size_t;
  typedef logic [XLEN/8-1:0] be_t;

  // Access size codes
  localparam size_t SIZE_BYTE = 2'd0;
  localparam size_t SIZE_HALF = 2'd1;
  localparam size_t SIZE_WORD = 2'd2;

  // Request buffer geometry
  localparam int unsigned REQBUF_DEPTH = 2;
  localparam int unsigned REQBUF_PTR_W = $clog2(REQBUF_DEPTH);

  typedef logic [REQBUF_PTR_W-1:0] reqbuf_ptr_t;
  typedef logic [REQBUF_PTR_W:0]   reqbuf_cnt_t;

  localparam reqbuf_ptr_t REQBUF_LAST_PTR = reqbuf_ptr_t'(REQBUF_DEPTH - 1);
  localparam reqbuf_cnt_t REQBUF_FULL_CNT = reqbuf_cnt_t'(REQBUF_DEPTH);

  ////////////////////////////////////////////////////////////////////////////
  // Fixed memory map
  ////////////////////////////////////////////////////////////////////////////

  // RAM region allows reads and writes
  localparam addr_t RAM_BASE  = 32'h0000_0000;
  localparam addr_t RAM_LIMIT = 32'h0000_0FFF;
  // ROM region allows reads only
  localparam addr_t ROM_BASE  = 32'h0000_1000;
  localparam addr_t ROM_LIMIT = 32'h0000_1FFF;

  ////////////////////////////////////////////////////////////////////////////
  // Request and response bundles
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic  we;
    size_t size;
    addr_t adr;
    word_t wdata;
  } cpu_req_t;

  typedef struct packed {
    word_t rdata;
    logic  err;
    logic  misaligned;
  } cpu_rsp_t;

  // Word aligned single beat transfer
  typedef struct packed {
    logic  we;
    addr_t adr;
    be_t   be;
    word_t wdata;
  } bus_req_t;

endpackage

`default_nettype wire
